/* bench/soc_asserts.sv */
`timescale 1ns/1ps

module soc_asserts (
    input logic clk_i,
    input logic rst_n_i,
    input logic data_req_i,
    input logic data_gnt_o,
    input logic data_rvalid_o,
    input logic uart_tx_o
);
    import soc_periph_pkg::*;

    logic accept;

    assign accept = data_req_i && data_gnt_o;

    // One response cycle per accepted request
    rvalid_after_accept: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) accept |=> data_rvalid_o
    ) else $error("rvalid missing one cycle after an accepted request");

    rvalid_has_request: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) data_rvalid_o |-> $past(accept)
    ) else $error("rvalid raised without a request accepted the cycle before");

    // From the second reset edge on, the serializer is in its idle state
    tx_idle_in_reset: assert property (
        @(posedge clk_i) (!rst_n_i && $past(!rst_n_i)) |-> (uart_tx_o == UART_LINE_IDLE)
    ) else $error("serial line not idle during reset");

endmodule

bind soc_data_top soc_asserts top_asserts (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .data_req_i    ( data_req_i    ),
    .data_gnt_o    ( data_gnt_o    ),
    .data_rvalid_o ( data_rvalid_o ),
    .uart_tx_o     ( uart_tx_o     )
);

/* bench/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    localparam int CLKS_PER_BIT   = 16;
    localparam int FRAME_CYCLES   = 10 * CLKS_PER_BIT;
    // Six frames plus the bus traffic, with a wide margin
    localparam int TIMEOUT_CYCLES = 4 * (6 * FRAME_CYCLES + 300);
    localparam int MEM_WORDS      = 8 * 1024 / 4;
    localparam int NUM_WORDS      = 32;

    logic                      clk;
    logic                      rst_n;
    logic                      req;
    bus_addr_u                 addr;
    logic                      we;
    logic [BUS_BE_WIDTH-1:0]   be;
    logic [BUS_DATA_WIDTH-1:0] wdata;
    logic                      gnt;
    logic                      rvalid;
    logic [BUS_DATA_WIDTH-1:0] rdata;
    logic                      tx;

    int                        cycle;
    int                        errors;
    int                        checks;
    int                        last_gnt_cycle;
    logic [BUS_DATA_WIDTH-1:0] model [MEM_WORDS];
    logic [10:0]               word_idx [NUM_WORDS];
    logic [7:0]                rx_q [$];

    soc_data_top #(
        .CLKS_PER_BIT ( CLKS_PER_BIT )
    ) UUT (
        .clk_i         ( clk    ),
        .rst_n_i       ( rst_n  ),
        .data_req_i    ( req    ),
        .data_addr_i   ( addr   ),
        .data_we_i     ( we     ),
        .data_be_i     ( be     ),
        .data_wdata_i  ( wdata  ),
        .data_gnt_o    ( gnt    ),
        .data_rvalid_o ( rvalid ),
        .data_rdata_o  ( rdata  ),
        .uart_tx_o     ( tx     )
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////
    // Serial line monitor
    //////////////////////////////
    always begin
        logic [7:0] rx_byte;
        logic       start_ok;
        @(negedge tx);
        if (rst_n) begin
            // Move to mid-bit, then one bit period per sample
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            start_ok = (tx == ~UART_LINE_IDLE);
            for (int b = 0; b < 8; b++) begin
                repeat (CLKS_PER_BIT) @(negedge clk);
                rx_byte[b] = tx;
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (!start_ok || tx != UART_LINE_IDLE) begin
                errors++;
                $display("Framing error on the serial line for byte %h", rx_byte);
            end
            rx_q.push_back(rx_byte);
        end
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_word(input string name, input logic [BUS_DATA_WIDTH-1:0] expected,
                              input logic [BUS_DATA_WIDTH-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        if (cond !== 1'b1) begin
            errors++;
            $display("Failure: %s", what);
        end
    endtask

    //////////////////////////////
    // Bus helpers
    //////////////////////////////
    function automatic bus_addr_u data_addr_of(input logic [10:0] idx);
        bus_addr_u a;
        a.flat         = '0;
        a.split.region = REGION_DATA;
        a.split.offset = REGION_OFFSET_WIDTH'({idx, 2'b00});
        return a;
    endfunction

    function automatic bus_addr_u uart_reg_addr(input int offset);
        bus_addr_u a;
        a.flat         = '0;
        a.split.region = REGION_PERIPHERAL;
        a.split.offset = REGION_OFFSET_WIDTH'(offset);
        return a;
    endfunction

    task automatic bus_access(input bus_addr_u a, input logic write,
                              input logic [BUS_BE_WIDTH-1:0] lanes,
                              input logic [BUS_DATA_WIDTH-1:0] wd,
                              output logic [BUS_DATA_WIDTH-1:0] rd);
        @(posedge clk);
        req   <= 1'b1;
        addr  <= a;
        we    <= write;
        be    <= lanes;
        wdata <= wd;
        @(negedge clk);
        while (!gnt) @(negedge clk);
        last_gnt_cycle = cycle;
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        require(rvalid, "rvalid not raised one cycle after the grant");
        rd = rdata;
    endtask

    task automatic bus_write(input string name, input bus_addr_u a,
                             input logic [BUS_BE_WIDTH-1:0] lanes,
                             input logic [BUS_DATA_WIDTH-1:0] wd);
        logic [BUS_DATA_WIDTH-1:0] rd;
        bus_access(a, 1'b1, lanes, wd, rd);
        check_word(name, '0, rd);
    endtask

    task automatic bus_read(input bus_addr_u a, output logic [BUS_DATA_WIDTH-1:0] rd);
        bus_access(a, 1'b0, '1, '0, rd);
    endtask

    task automatic wait_rx(input int count);
        while (rx_q.size() < count) @(posedge clk);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    task automatic test_reset_state();
        logic [BUS_DATA_WIDTH-1:0] rd;
        @(negedge clk);
        require(!gnt, "data_gnt_o high after reset");
        require(!rvalid, "data_rvalid_o high after reset");
        require(tx == UART_LINE_IDLE, "serial line not idle after reset");
        bus_read(uart_reg_addr(UART_STATUS_OFFSET), rd);
        check_word("reset_state", '0, rd);
    endtask

    task automatic test_mem_words();
        logic [BUS_DATA_WIDTH-1:0] wd;
        for (int i = 0; i < NUM_WORDS; i++) begin
            word_idx[i] = 11'($urandom_range(MEM_WORDS - 1, 0));
            wd          = $urandom;
            bus_write("mem_words", data_addr_of(word_idx[i]), '1, wd);
            model[word_idx[i]] = wd;
        end
        // Reads in consecutive cycles, each response overlaps the next request
        for (int i = 0; i <= NUM_WORDS; i++) begin
            @(posedge clk);
            if (i < NUM_WORDS) begin
                req  <= 1'b1;
                we   <= 1'b0;
                be   <= '1;
                addr <= data_addr_of(word_idx[i]);
            end else begin
                req <= 1'b0;
            end
            @(negedge clk);
            if (i < NUM_WORDS) begin
                require(gnt, "memory read not granted in its request cycle");
            end
            if (i > 0) begin
                require(rvalid, "rvalid missing in back-to-back reads");
                check_word("mem_words", model[word_idx[i-1]], rdata);
            end
        end
    endtask

    task automatic test_mem_byte_lanes();
        logic [10:0]               idx;
        logic [BUS_BE_WIDTH-1:0]   lanes;
        logic [BUS_DATA_WIDTH-1:0] wd;
        logic [BUS_DATA_WIDTH-1:0] rd;
        for (int i = 0; i < 16; i++) begin
            idx   = word_idx[$urandom_range(NUM_WORDS - 1, 0)];
            lanes = BUS_BE_WIDTH'($urandom);
            wd    = $urandom;
            bus_write("mem_byte_lanes", data_addr_of(idx), lanes, wd);
            for (int lane = 0; lane < BUS_BE_WIDTH; lane++) begin
                if (lanes[lane]) begin
                    model[idx][lane*8 +: 8] = wd[lane*8 +: 8];
                end
            end
            bus_read(data_addr_of(idx), rd);
            check_word("mem_byte_lanes", model[idx], rd);
        end
    endtask

    task automatic test_uart_single();
        logic [7:0]                tx_byte;
        logic [BUS_DATA_WIDTH-1:0] busy_word;
        logic [BUS_DATA_WIDTH-1:0] rd;
        tx_byte   = 8'($urandom);
        busy_word = '0;
        busy_word[UART_STATUS_BUSY_BIT] = 1'b1;
        bus_write("uart_single", uart_reg_addr(UART_TXDATA_OFFSET), '1,
                  BUS_DATA_WIDTH'(tx_byte));
        bus_read(uart_reg_addr(UART_STATUS_OFFSET), rd);
        check_word("uart_single", busy_word, rd);
        wait_rx(1);
        check_byte("uart_single", tx_byte, rx_q.pop_front());
        // Stop bit ends within half a bit after the monitor sample
        repeat (CLKS_PER_BIT) @(posedge clk);
        bus_read(uart_reg_addr(UART_STATUS_OFFSET), rd);
        check_word("uart_single", '0, rd);
    endtask

    task automatic test_uart_back_to_back();
        logic [7:0] tx_bytes [3];
        int         gnt_at [3];
        for (int i = 0; i < 3; i++) begin
            tx_bytes[i] = 8'($urandom);
            bus_write("uart_back_to_back", uart_reg_addr(UART_TXDATA_OFFSET), '1,
                      BUS_DATA_WIDTH'(tx_bytes[i]));
            gnt_at[i] = last_gnt_cycle;
        end
        for (int i = 1; i < 3; i++) begin
            require(gnt_at[i] - gnt_at[i-1] > FRAME_CYCLES,
                    "UART data write granted before the previous frame ended");
        end
        wait_rx(3);
        for (int i = 0; i < 3; i++) begin
            check_byte("uart_back_to_back", tx_bytes[i], rx_q.pop_front());
        end
        repeat (CLKS_PER_BIT) @(posedge clk);
    endtask

    task automatic test_unmapped_region();
        bus_addr_u                 a;
        logic [BUS_DATA_WIDTH-1:0] rd;
        a              = data_addr_of(word_idx[0]);
        a.split.region = REGION_ID_WIDTH'(1);
        bus_write("unmapped_region", a, '1, ~model[word_idx[0]]);
        bus_read(a, rd);
        check_word("unmapped_region", '0, rd);
        bus_read(data_addr_of(word_idx[0]), rd);
        check_word("unmapped_region", model[word_idx[0]], rd);
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        req            = 1'b0;
        addr           = '0;
        we             = 1'b0;
        be             = '0;
        wdata          = '0;
        cycle          = 0;
        errors         = 0;
        checks         = 0;
        last_gnt_cycle = 0;
        void'($urandom(32'ha886_7f4f));
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        test_reset_state();
        test_mem_words();
        test_mem_byte_lanes();
        test_uart_single();
        test_uart_back_to_back();
        test_unmapped_region();

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* common/soc_bus_pkg.sv */
package soc_bus_pkg;

    //////////////////////////////
    // Bus widths
    //////////////////////////////
    localparam int BUS_ADDR_WIDTH      = 32;
    localparam int BUS_DATA_WIDTH      = 32;
    localparam int BUS_BE_WIDTH        = 4;

    //////////////////////////////
    // Region map
    //////////////////////////////
    localparam int REGION_OFFSET_WIDTH = 28;
    localparam int REGION_ID_WIDTH     = 4;

    localparam logic [REGION_ID_WIDTH-1:0] REGION_PERIPHERAL = 4'd0;
    localparam logic [REGION_ID_WIDTH-1:0] REGION_DATA       = 4'd2;

    // Same address word, seen flat or as region over offset
    typedef union packed {
        logic [BUS_ADDR_WIDTH-1:0] flat;
        struct packed {
            logic [REGION_ID_WIDTH-1:0]     region;
            logic [REGION_OFFSET_WIDTH-1:0] offset;
        } split;
    } bus_addr_u;

endpackage

/* common/soc_periph_pkg.sv */
package soc_periph_pkg;

    //////////////////////////////
    // UART register map
    //////////////////////////////
    localparam int UART_TXDATA_OFFSET   = 0;
    localparam int UART_STATUS_OFFSET   = 4;

    // Status word layout
    localparam int UART_STATUS_BUSY_BIT = 0;

    //////////////////////////////
    // Serial line levels
    //////////////////////////////
    // Idle and stop bit share this level, start bit is the inverse
    localparam logic UART_LINE_IDLE     = 1'b1;

endpackage

/* data_mem/data_mem.sv */
`timescale 1ns/1ps

module data_mem #(
    parameter int DATA_MEMORY_SIZE_IN_KB = 8
) (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        req_i,
    input  logic [soc_bus_pkg::REGION_OFFSET_WIDTH-1:0] offset_i,
    input  logic                                        we_i,
    input  logic [soc_bus_pkg::BUS_BE_WIDTH-1:0]        be_i,
    input  logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0]      wdata_i,
    output logic                                        gnt_o,
    output logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0]      rdata_o
);
    import soc_bus_pkg::*;

    localparam int WORD_BYTES  = BUS_DATA_WIDTH / 8;
    localparam int DEPTH       = DATA_MEMORY_SIZE_IN_KB * 1024 / WORD_BYTES;
    localparam int INDEX_WIDTH = $clog2(DEPTH);
    localparam int LANE_SHIFT  = $clog2(WORD_BYTES);

    logic [BUS_DATA_WIDTH-1:0] mem [DEPTH];
    logic [INDEX_WIDTH-1:0]    word_index;

    // Offset bits above the array size wrap around
    assign word_index = offset_i[LANE_SHIFT +: INDEX_WIDTH];

    // Single cycle memory, never stalls
    assign gnt_o = 1'b1;

    //////////////////////////////
    // Byte lane writes
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            for (int lane = 0; lane < BUS_BE_WIDTH; lane++) begin
                if (be_i[lane]) begin
                    mem[word_index][lane*8 +: 8] <= wdata_i[lane*8 +: 8];
                end
            end
        end
    end

    //////////////////////////////
    // Registered read
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else if (req_i && !we_i) begin
            rdata_o <= mem[word_index];
        end
    end

endmodule

/* hdl/soc_bus_front.sv */
`timescale 1ns/1ps

module soc_bus_front (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,

    // Core data port
    input  logic                                        data_req_i,
    input  soc_bus_pkg::bus_addr_u                      data_addr_i,
    input  logic                                        data_we_i,
    input  logic [soc_bus_pkg::BUS_BE_WIDTH-1:0]        data_be_i,
    input  logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0]      data_wdata_i,
    output logic                                        data_gnt_o,
    output logic                                        data_rvalid_o,
    output logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0]      data_rdata_o,

    // Data memory
    output logic                                        mem_req_o,
    input  logic                                        mem_gnt_i,
    input  logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0]      mem_rdata_i,

    // UART
    output logic                                        uart_req_o,
    input  logic                                        uart_gnt_i,
    input  logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0]      uart_rdata_i,

    // Shared toward both targets
    output logic [soc_bus_pkg::REGION_OFFSET_WIDTH-1:0] tgt_offset_o,
    output logic                                        tgt_we_o,
    output logic [soc_bus_pkg::BUS_BE_WIDTH-1:0]        tgt_be_o,
    output logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0]      tgt_wdata_o
);
    import soc_bus_pkg::*;

    logic [REGION_ID_WIDTH-1:0] region;
    logic                       hit_mem;
    logic                       hit_uart;
    logic                       accept;

    logic                       resp_valid_q;
    logic                       resp_read_q;
    logic [REGION_ID_WIDTH-1:0] resp_region_q;

    //////////////////////////////
    // Request side
    //////////////////////////////
    assign region     = data_addr_i.split.region;
    assign hit_mem    = (region == REGION_DATA);
    assign hit_uart   = (region == REGION_PERIPHERAL);

    assign mem_req_o  = data_req_i && hit_mem;
    assign uart_req_o = data_req_i && hit_uart;

    assign tgt_offset_o = data_addr_i.split.offset;
    assign tgt_we_o     = data_we_i;
    assign tgt_be_o     = data_be_i;
    assign tgt_wdata_o  = data_wdata_i;

    // Unmapped regions are granted here and never reach a target
    always_comb begin
        if (hit_mem) begin
            data_gnt_o = data_req_i && mem_gnt_i;
        end else if (hit_uart) begin
            data_gnt_o = data_req_i && uart_gnt_i;
        end else begin
            data_gnt_o = data_req_i;
        end
    end

    assign accept = data_req_i && data_gnt_o;

    //////////////////////////////
    // Response side
    //////////////////////////////
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            resp_region_q <= region;
            resp_read_q   <= !data_we_i;
        end
    end

    assign data_rvalid_o = resp_valid_q;

    // Writes and unmapped reads answer with zero
    always_comb begin
        data_rdata_o = '0;
        if (resp_valid_q && resp_read_q) begin
            if (resp_region_q == REGION_DATA) begin
                data_rdata_o = mem_rdata_i;
            end else if (resp_region_q == REGION_PERIPHERAL) begin
                data_rdata_o = uart_rdata_i;
            end
        end
    end

endmodule

/* hdl/soc_data_top.sv */
`timescale 1ns/1ps

module soc_data_top #(
    parameter int DATA_MEMORY_SIZE_IN_KB = 8,
    parameter int CLKS_PER_BIT           = 868
) (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,

    input  logic                                   data_req_i,
    input  soc_bus_pkg::bus_addr_u                 data_addr_i,
    input  logic                                   data_we_i,
    input  logic [soc_bus_pkg::BUS_BE_WIDTH-1:0]   data_be_i,
    input  logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0] data_wdata_i,
    output logic                                   data_gnt_o,
    output logic                                   data_rvalid_o,
    output logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0] data_rdata_o,

    output logic                                   uart_tx_o
);
    import soc_bus_pkg::*;

    logic                           mem_req_w;
    logic                           mem_gnt_w;
    logic [BUS_DATA_WIDTH-1:0]      mem_rdata_w;

    logic                           uart_req_w;
    logic                           uart_gnt_w;
    logic [BUS_DATA_WIDTH-1:0]      uart_rdata_w;

    logic [REGION_OFFSET_WIDTH-1:0] tgt_offset_w;
    logic                           tgt_we_w;
    logic [BUS_BE_WIDTH-1:0]        tgt_be_w;
    logic [BUS_DATA_WIDTH-1:0]      tgt_wdata_w;

    soc_bus_front bus_front (
        .clk_i         ( clk_i         ),
        .rst_n_i       ( rst_n_i       ),
        .data_req_i    ( data_req_i    ),
        .data_addr_i   ( data_addr_i   ),
        .data_we_i     ( data_we_i     ),
        .data_be_i     ( data_be_i     ),
        .data_wdata_i  ( data_wdata_i  ),
        .data_gnt_o    ( data_gnt_o    ),
        .data_rvalid_o ( data_rvalid_o ),
        .data_rdata_o  ( data_rdata_o  ),
        .mem_req_o     ( mem_req_w     ),
        .mem_gnt_i     ( mem_gnt_w     ),
        .mem_rdata_i   ( mem_rdata_w   ),
        .uart_req_o    ( uart_req_w    ),
        .uart_gnt_i    ( uart_gnt_w    ),
        .uart_rdata_i  ( uart_rdata_w  ),
        .tgt_offset_o  ( tgt_offset_w  ),
        .tgt_we_o      ( tgt_we_w      ),
        .tgt_be_o      ( tgt_be_w      ),
        .tgt_wdata_o   ( tgt_wdata_w   )
    );

    data_mem #(
        .DATA_MEMORY_SIZE_IN_KB ( DATA_MEMORY_SIZE_IN_KB )
    ) data_memory (
        .clk_i    ( clk_i        ),
        .rst_n_i  ( rst_n_i      ),
        .req_i    ( mem_req_w    ),
        .offset_i ( tgt_offset_w ),
        .we_i     ( tgt_we_w     ),
        .be_i     ( tgt_be_w     ),
        .wdata_i  ( tgt_wdata_w  ),
        .gnt_o    ( mem_gnt_w    ),
        .rdata_o  ( mem_rdata_w  )
    );

    uart_tx_regs #(
        .CLKS_PER_BIT ( CLKS_PER_BIT )
    ) uart_tx (
        .clk_i    ( clk_i        ),
        .rst_n_i  ( rst_n_i      ),
        .req_i    ( uart_req_w   ),
        .offset_i ( tgt_offset_w ),
        .we_i     ( tgt_we_w     ),
        .wdata_i  ( tgt_wdata_w  ),
        .gnt_o    ( uart_gnt_w   ),
        .rdata_o  ( uart_rdata_w ),
        .tx_o     ( uart_tx_o    )
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f sources.f -o tb_soc

./obj_dir/tb_soc | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

/* sources.f */
common/soc_bus_pkg.sv
common/soc_periph_pkg.sv
data_mem/data_mem.sv
uart/uart_tx_regs.sv
hdl/soc_bus_front.sv
hdl/soc_data_top.sv
bench/soc_asserts.sv
bench/tb_soc.sv

/* uart/uart_tx_regs.sv */
`timescale 1ns/1ps

module uart_tx_regs #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                                        clk_i,
    input  logic                                        rst_n_i,
    input  logic                                        req_i,
    input  logic [soc_bus_pkg::REGION_OFFSET_WIDTH-1:0] offset_i,
    input  logic                                        we_i,
    input  logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0]      wdata_i,
    output logic                                        gnt_o,
    output logic [soc_bus_pkg::BUS_DATA_WIDTH-1:0]      rdata_o,
    output logic                                        tx_o
);
    import soc_bus_pkg::*;
    import soc_periph_pkg::*;

    localparam int BAUD_WIDTH = $clog2(CLKS_PER_BIT);
    localparam logic [BAUD_WIDTH-1:0] BAUD_LAST = BAUD_WIDTH'(CLKS_PER_BIT - 1);

    // Frame states
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

    logic [1:0]                state;
    logic [BAUD_WIDTH-1:0]     baud_cnt;
    logic [2:0]                bit_cnt;
    logic [7:0]                shift_q;
    logic                      baud_last;
    logic                      busy;
    logic                      sel_txdata;
    logic                      sel_status;
    logic                      tx_start;
    logic [BUS_DATA_WIDTH-1:0] status_word;

    //////////////////////////////
    // Register decode
    //////////////////////////////
    assign sel_txdata = (offset_i == REGION_OFFSET_WIDTH'(UART_TXDATA_OFFSET));
    assign sel_status = (offset_i == REGION_OFFSET_WIDTH'(UART_STATUS_OFFSET));
    assign busy       = (state != ST_IDLE);

    // Data writes stall while a frame is on the line
    assign gnt_o    = !(we_i && sel_txdata && busy);
    assign tx_start = req_i && gnt_o && we_i && sel_txdata;

    always_comb begin
        status_word = '0;
        status_word[UART_STATUS_BUSY_BIT] = busy;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rdata_o <= '0;
        end else if (req_i && gnt_o && !we_i) begin
            rdata_o <= sel_status ? status_word : '0;
        end
    end

    //////////////////////////////
    // Serializer
    //////////////////////////////
    assign baud_last = (baud_cnt == BAUD_LAST);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state    <= ST_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            baud_cnt <= baud_last ? '0 : baud_cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    baud_cnt <= '0;
                    if (tx_start) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    if (baud_last) begin
                        state   <= ST_DATA;
                        bit_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    if (baud_last) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= ST_STOP;
                        end
                    end
                end
                default: begin
                    if (baud_last) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // LSB first, next bit moves down at each data bit boundary
    always_ff @(posedge clk_i) begin
        if (tx_start) begin
            shift_q <= wdata_i[7:0];
        end else if (state == ST_DATA && baud_last) begin
            shift_q <= shift_q >> 1;
        end
    end

    always_comb begin
        case (state)
            ST_START: tx_o = ~UART_LINE_IDLE;
            ST_DATA:  tx_o = shift_q[0];
            default:  tx_o = UART_LINE_IDLE;
        endcase
    end

endmodule
